// File: vlog.f
source/rvc_pkg.sv
source/rvc_q0_expander.sv
source/rvc_q1_expander.sv
source/rvc_q2_expander.sv
source/rvc_decompressor.sv
test/rvc_tb_clock.sv
test/rvc_tb.sv

// File: test/rvc_tb.sv
`default_nettype none

module rvc_tb import rvc_pkg::*; ();

  localparam int MAX_ROWS     = 64;
  localparam int EDGE_TIMEOUT = 40;  // Two clock periods in time units
  localparam int RST_CYCLES   = 16;
  localparam int N_RANDOM     = 32;
  localparam logic [15:0] LFSR_SEED = 16'd82;

  logic               clk;
  logic               rst;  // Local reset phase flag
  rvc_word_u          instr_c;
  logic [INSTR_W-1:0] instr_x;
  logic               is_comp;
  logic               illegal;

  int instr_errs;
  int flag_errs;
  int timeout_errs;

  logic [15:0] lfsr_state;

  // Stimulus table columns
  string               row_name  [MAX_ROWS];
  logic [CINSTR_W-1:0] row_word  [MAX_ROWS];
  logic [INSTR_W-1:0]  row_instr [MAX_ROWS];
  logic                row_ill   [MAX_ROWS];
  logic                row_comp  [MAX_ROWS];
  int                  n_rows;

  rvc_tb_clock u_clock (
    .o_clk (clk)
  );

  rvc_decompressor DUT (
    .i_instr_compressed (instr_c),
    .o_instr_expanded   (instr_x),
    .o_is_compressed    (is_comp),
    .o_illegal          (illegal)
  );

  // ========================================
  // Helpers
  // ========================================

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One LFSR step per bit with op forced to 11
  task automatic random_word(output logic [CINSTR_W-1:0] word);
    int b;
    word = '0;
    for (b = 2; b < CINSTR_W; b++) begin
      word[b]    = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    word[1:0] = QUAD_3;
  endtask

  // Polls clk until it moves to the given level
  task automatic wait_edge(input logic level, output bit ok);
    int   steps;
    logic prev;
    ok    = 1'b0;
    steps = 0;
    prev  = clk;
    while (!ok && steps < EDGE_TIMEOUT) begin
      #1;
      steps++;
      if (prev !== level && clk === level) ok = 1'b1;
      prev = clk;
    end
    if (!ok) begin
      $display("Timeout: clock did not reach level %0b within %0d time units",
               level, EDGE_TIMEOUT);
      timeout_errs++;
    end
  endtask

  task automatic check_instr(input string name, input logic [INSTR_W-1:0] exp,
                             input logic [INSTR_W-1:0] act);
    if (act !== exp) begin
      $display("ERR %s expected=%08h actual=%08h", name, exp, act);
      instr_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected=%0b actual=%0b", name, exp, act);
      flag_errs++;
    end
  endtask

  task automatic add_row(input string name, input logic [CINSTR_W-1:0] word,
                         input logic [INSTR_W-1:0] exp_instr, input logic exp_ill,
                         input logic exp_comp);
    row_name[n_rows]  = name;
    row_word[n_rows]  = word;
    row_instr[n_rows] = exp_instr;
    row_ill[n_rows]   = exp_ill;
    row_comp[n_rows]  = exp_comp;
    n_rows++;
  endtask

  // Drive on falling edge and sample on the next rising edge
  task automatic apply_row(input string name, input logic [CINSTR_W-1:0] word,
                           input logic [INSTR_W-1:0] exp_instr, input logic exp_ill,
                           input logic exp_comp);
    bit ok;
    wait_edge(1'b0, ok);
    if (ok) begin
      instr_c = word;
      wait_edge(1'b1, ok);
    end
    if (ok) begin
      check_flag({name, " illegal"}, exp_ill, illegal);
      check_flag({name, " compressed"}, exp_comp, is_comp);
      if (!exp_ill) check_instr(name, exp_instr, instr_x);  // Expansion undefined if illegal
    end
  endtask

  // ========================================
  // Stimulus table
  // ========================================
  // Illegal rows carry a zero expansion that is never compared
  task automatic load_table();
    add_row("q0 addi4spn x8 4",    16'h0040, 32'h0041_0413, 1'b0, 1'b1);
    add_row("q0 addi4spn x15 1020", 16'h1FFC, 32'h3FC1_0793, 1'b0, 1'b1);
    add_row("q0 lw x9 4(x10)",     16'h4144, 32'h0045_2483, 1'b0, 1'b1);
    add_row("q0 sw x9 8(x10)",     16'hC504, 32'h0095_2423, 1'b0, 1'b1);
    add_row("q0 addi4spn zero",    16'h0008, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q0 f3 001",           16'h2000, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q0 f3 011 flw",       16'h6000, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q0 f3 100",           16'h8000, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q0 f3 101",           16'hA000, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q0 f3 111 fsw",       16'hE000, 32'h0000_0000, 1'b1, 1'b1);
    // Quadrant 1 arithmetic and immediates
    add_row("q1 nop",              16'h0001, 32'h0000_0013, 1'b0, 1'b1);
    add_row("q1 addi x10 -1",      16'h157D, 32'hFFF5_0513, 1'b0, 1'b1);  // Sign extension
    add_row("q1 li x11 -32",       16'h5581, 32'hFE00_0593, 1'b0, 1'b1);
    add_row("q1 addi16sp 16",      16'h6141, 32'h0101_0113, 1'b0, 1'b1);
    add_row("q1 addi16sp -512",    16'h7101, 32'hE001_0113, 1'b0, 1'b1);
    add_row("q1 lui x12 1",        16'h6605, 32'h0000_1637, 1'b0, 1'b1);
    add_row("q1 lui x12 -1",       16'h767D, 32'hFFFF_F637, 1'b0, 1'b1);
    add_row("q1 srli x8 3",        16'h800D, 32'h0034_5413, 1'b0, 1'b1);
    add_row("q1 srai x9 31",       16'h84FD, 32'h41F4_D493, 1'b0, 1'b1);
    add_row("q1 andi x10 -2",      16'h9979, 32'hFFE5_7513, 1'b0, 1'b1);
    add_row("q1 sub x8 x9",        16'h8C05, 32'h4094_0433, 1'b0, 1'b1);
    add_row("q1 xor x10 x11",      16'h8D2D, 32'h00B5_4533, 1'b0, 1'b1);
    add_row("q1 or x12 x13",       16'h8E55, 32'h00D6_6633, 1'b0, 1'b1);
    add_row("q1 and x14 x15",      16'h8F7D, 32'h00F7_7733, 1'b0, 1'b1);
    add_row("q1 addi16sp zero",    16'h6101, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q1 lui zero imm",     16'h6601, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q1 lui rd x0",        16'h6005, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q1 srli bit12",       16'h900D, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q1 subw rv64",        16'h9C05, 32'h0000_0000, 1'b1, 1'b1);
    // Quadrant 1 control flow
    add_row("q1 j +8",             16'hA021, 32'h0080_006F, 1'b0, 1'b1);
    add_row("q1 j -2",             16'hBFFD, 32'hFFFF_F06F, 1'b0, 1'b1);
    add_row("q1 jal +16",          16'h2801, 32'h0100_00EF, 1'b0, 1'b1);
    add_row("q1 jal -2048",        16'h3001, 32'h801F_F0EF, 1'b0, 1'b1);
    add_row("q1 beqz x8 +8",       16'hC401, 32'h0004_0463, 1'b0, 1'b1);
    add_row("q1 beqz x9 -256",     16'hD081, 32'hF004_80E3, 1'b0, 1'b1);
    add_row("q1 bnez x15 -4",      16'hFFF5, 32'hFE07_9EE3, 1'b0, 1'b1);
    add_row("q1 bnez x10 +254",    16'hED7D, 32'h0E05_1F63, 1'b0, 1'b1);
    // Quadrant 2
    add_row("q2 slli x10 4",       16'h0512, 32'h0045_1513, 1'b0, 1'b1);
    add_row("q2 lwsp x11 12",      16'h45B2, 32'h00C1_2583, 1'b0, 1'b1);
    add_row("q2 swsp x1 252",      16'hDF86, 32'h0E11_2E23, 1'b0, 1'b1);
    add_row("q2 jr x5",            16'h8282, 32'h0002_8067, 1'b0, 1'b1);
    add_row("q2 mv x10 x11",       16'h852E, 32'h00B0_0533, 1'b0, 1'b1);
    add_row("q2 ebreak",           16'h9002, 32'h0010_0073, 1'b0, 1'b1);
    add_row("q2 jalr x6",          16'h9302, 32'h0003_00E7, 1'b0, 1'b1);
    add_row("q2 add x10 x11",      16'h952E, 32'h00B5_0533, 1'b0, 1'b1);
    add_row("q2 slli rd x0",       16'h0012, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q2 lwsp rd x0",       16'h4032, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q2 jr x0",            16'h8002, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q2 mv rd x0",         16'h802E, 32'h0000_0000, 1'b1, 1'b1);
    add_row("q2 f3 011 flwsp",     16'h6002, 32'h0000_0000, 1'b1, 1'b1);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin : main_seq
    bit                  ok;
    int                  cycles;
    int                  i;
    logic [CINSTR_W-1:0] w;
    rst          = 1'b1;
    instr_c      = '0;  // Held at zero through reset
    lfsr_state   = LFSR_SEED;
    instr_errs   = 0;
    flag_errs    = 0;
    timeout_errs = 0;
    n_rows       = 0;
    load_table();

    ok     = 1'b1;
    cycles = 0;
    while (rst && ok) begin
      wait_edge(1'b1, ok);
      cycles++;
      if (cycles >= RST_CYCLES) rst = 1'b0;
    end

    for (i = 0; i < n_rows && timeout_errs == 0; i++) begin
      apply_row(row_name[i], row_word[i], row_instr[i], row_ill[i], row_comp[i]);
    end

    // Full-width words pass through zero-extended
    for (i = 0; i < N_RANDOM && timeout_errs == 0; i++) begin
      random_word(w);
      apply_row($sformatf("passthrough %0d", i), w, {16'h0000, w}, 1'b0, 1'b0);
    end

    $display("Errors: instr=%0d flag=%0d timeout=%0d", instr_errs, flag_errs, timeout_errs);
    if (instr_errs + flag_errs + timeout_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : rvc_tb

`default_nettype wire

// File: test/rvc_tb_clock.sv
`default_nettype none

module rvc_tb_clock (
  output logic o_clk
);

  localparam int HALF_PERIOD = 10;  // Period 20

  initial begin
    o_clk = 1'b0;
  end

  // Free-running, never stops
  always #HALF_PERIOD o_clk = ~o_clk;

endmodule : rvc_tb_clock

`default_nettype wire

// File: source/rvc_decompressor.sv
`default_nettype none

module rvc_decompressor import rvc_pkg::*; (
  input  rvc_word_u          i_instr_compressed,
  output logic [INSTR_W-1:0] o_instr_expanded,
  output logic               o_is_compressed,
  output logic               o_illegal
);

  expand_result_t q0_res;
  expand_result_t q1_res;
  expand_result_t q2_res;
  expand_result_t sel_res;  // After quadrant mux

  // ========================================
  // Per-quadrant expanders, all see the word
  // ========================================
  rvc_q0_expander u_q0 (
    .i_word   (i_instr_compressed),
    .o_result (q0_res)
  );

  rvc_q1_expander u_q1 (
    .i_word   (i_instr_compressed),
    .o_result (q1_res)
  );

  rvc_q2_expander u_q2 (
    .i_word   (i_instr_compressed),
    .o_result (q2_res)
  );

  // Only quadrant decode in the design
  always_comb begin
    unique case (i_instr_compressed.cr.op)
      QUAD_0:  sel_res = q0_res;
      QUAD_1:  sel_res = q1_res;
      QUAD_2:  sel_res = q2_res;
      default: begin  // Full-width word, low half passes through
        sel_res.instr   = {{(INSTR_W - CINSTR_W){1'b0}}, i_instr_compressed};
        sel_res.illegal = 1'b0;
      end
    endcase
  end

  assign o_instr_expanded = sel_res.instr;
  assign o_illegal        = sel_res.illegal;
  assign o_is_compressed  = (i_instr_compressed.cr.op != QUAD_3);

endmodule : rvc_decompressor

`default_nettype wire

// File: source/rvc_q2_expander.sv
`default_nettype none

module rvc_q2_expander import rvc_pkg::*; (
  input  rvc_word_u      i_word,
  output expand_result_t o_result
);

  logic [2:0]       funct3;
  logic             bit12;     // funct4[0] in CR, shamt[5] in CI
  logic [REG_W-1:0] rd_full;   // rd and rs1 share 11:7
  logic [REG_W-1:0] rs2_full;  // 6:2

  assign funct3   = i_word.ci.funct3;
  assign bit12    = i_word.cr.funct4[0];
  assign rd_full  = i_word.cr.rd_rs1;
  assign rs2_full = i_word.cr.rs2;

  logic rd_zero;
  logic rs2_zero;

  assign rd_zero  = (rd_full == REG_ZERO);
  assign rs2_zero = (rs2_full == REG_ZERO);

  // ========================================
  // Stack-relative offsets, scaled by 4
  // ========================================
  logic [11:0] imm_lwsp;  // uimm[5|4:2|7:6]
  logic [7:0]  imm_swsp;  // uimm[5:2|7:6]

  assign imm_lwsp = {4'b0, i_word.ci.imm_lo[1:0], i_word.ci.imm_hi,
                     i_word.ci.imm_lo[4:2], 2'b00};
  assign imm_swsp = {i_word.css.imm[1:0], i_word.css.imm[5:2], 2'b00};

  // Expansions in parallel
  logic [INSTR_W-1:0] instr_slli, instr_lwsp, instr_swsp;
  logic [INSTR_W-1:0] instr_jr, instr_mv, instr_jalr, instr_add;

  assign instr_slli = {F7_BASE, i_word.ci.imm_lo, rd_full, F3_SLL, rd_full, OPC_OP_IMM};
  assign instr_lwsp = {imm_lwsp, REG_SP, F3_WORD, rd_full, OPC_LOAD};
  assign instr_swsp = {4'b0, imm_swsp[7:5], i_word.css.rs2, REG_SP, F3_WORD,
                       imm_swsp[4:0], OPC_STORE};

  // JALR uses funct3 000
  assign instr_jr   = {12'b0, rd_full, F3_ADD, REG_ZERO, OPC_JALR};
  assign instr_jalr = {12'b0, rd_full, F3_ADD, REG_RA, OPC_JALR};
  assign instr_mv   = {F7_BASE, rs2_full, REG_ZERO, F3_ADD, rd_full, OPC_OP};
  assign instr_add  = {F7_BASE, rs2_full, rd_full, F3_ADD, rd_full, OPC_OP};

  // ========================================
  // One-hot selects
  // ========================================
  logic f100;  // funct4 100x group
  logic sel_slli, sel_lwsp, sel_swsp;
  logic sel_jr, sel_mv, sel_ebreak, sel_jalr, sel_add;

  assign f100 = (funct3 == 3'b100);

  assign sel_slli = (funct3 == 3'b000);
  assign sel_lwsp = (funct3 == 3'b010);
  assign sel_swsp = (i_word.css.funct3 == 3'b110);

  assign sel_jr     = f100 && !bit12 && rs2_zero;
  assign sel_mv     = f100 && !bit12 && !rs2_zero;
  assign sel_ebreak = f100 && bit12 && rs2_zero && rd_zero;
  assign sel_jalr   = f100 && bit12 && rs2_zero && !rd_zero;
  assign sel_add    = f100 && bit12 && !rs2_zero;

  assign o_result.instr = ({INSTR_W{sel_slli}}   & instr_slli) |
                          ({INSTR_W{sel_lwsp}}   & instr_lwsp) |
                          ({INSTR_W{sel_swsp}}   & instr_swsp) |
                          ({INSTR_W{sel_jr}}     & instr_jr) |
                          ({INSTR_W{sel_mv}}     & instr_mv) |
                          ({INSTR_W{sel_ebreak}} & EBREAK_WORD) |
                          ({INSTR_W{sel_jalr}}   & instr_jalr) |
                          ({INSTR_W{sel_add}}    & instr_add);

  // Illegal checks
  logic illegal_slli, illegal_lwsp, illegal_jr, illegal_mv_add, illegal_reserved;

  assign illegal_slli   = sel_slli && (bit12 || rd_zero);
  assign illegal_lwsp   = sel_lwsp && rd_zero;
  assign illegal_jr     = sel_jr && rd_zero;  // rs1 is x0
  assign illegal_mv_add = (sel_mv || sel_add) && rd_zero;

  // 001, 101 and the dropped float codes 011, 111
  assign illegal_reserved = !(sel_slli || sel_lwsp || sel_swsp || f100);

  assign o_result.illegal = illegal_slli | illegal_lwsp | illegal_jr |
                            illegal_mv_add | illegal_reserved;

endmodule : rvc_q2_expander

`default_nettype wire

// File: source/rvc_q1_expander.sv
`default_nettype none

module rvc_q1_expander import rvc_pkg::*; (
  input  rvc_word_u      i_word,
  output expand_result_t o_result
);

  logic [2:0]       funct3;
  logic [REG_W-1:0] rd_full;    // rd/rs1 at 11:7
  logic [REG_W-1:0] rs1_prime;  // 9:7 -> x8..x15
  logic [REG_W-1:0] rs2_prime;  // 4:2 -> x8..x15
  logic [4:0]       shamt;      // RV32 shift, bit 12 must be clear

  assign funct3    = i_word.ci.funct3;
  assign rd_full   = i_word.ci.rd_rs1;
  assign rs1_prime = {PRIME_BASE, i_word.cb.rs1_p};
  assign rs2_prime = {PRIME_BASE, i_word.cb.imm_lo};
  assign shamt     = i_word.ci.imm_lo;

  // ========================================
  // Immediates
  // ========================================
  logic [11:0] imm_ci;        // ADDI, LI, ANDI
  logic [11:0] imm_addi16sp;  // Scaled by 16
  logic [19:0] imm_lui;       // Upper 20 bits
  logic [11:0] imm_j;         // Jump offset, bit 0 zero
  logic [8:0]  imm_b;         // Branch offset, bit 0 zero

  assign imm_ci = {{6{i_word.ci.imm_hi}}, i_word.ci.imm_hi, i_word.ci.imm_lo};

  // nzimm[9|4|6|8:7|5] from bits 12, 6:2
  assign imm_addi16sp = {{3{i_word.ci.imm_hi}}, i_word.ci.imm_lo[2:1],
                         i_word.ci.imm_lo[3], i_word.ci.imm_lo[0],
                         i_word.ci.imm_lo[4], 4'b0000};

  assign imm_lui = {{14{i_word.ci.imm_hi}}, i_word.ci.imm_hi, i_word.ci.imm_lo};

  // offset[11|4|9:8|10|6|7|3:1|5] in target bits
  assign imm_j = {i_word.cj.target[10], i_word.cj.target[6], i_word.cj.target[8:7],
                  i_word.cj.target[4], i_word.cj.target[5], i_word.cj.target[0],
                  i_word.cj.target[9], i_word.cj.target[3:1], 1'b0};

  // offset[8|4:3] at 12:10, offset[7:6|2:1|5] at 6:2
  assign imm_b = {i_word.cb.imm_hi, i_word.cb.mid, i_word.cb.imm_lo[0],
                  i_word.cb.funct2, i_word.cb.imm_lo[2:1], 1'b0};

  // ========================================
  // Expansions in parallel
  // ========================================
  logic [INSTR_W-1:0] instr_addi, instr_jal, instr_li, instr_addi16sp, instr_lui;
  logic [INSTR_W-1:0] instr_srli, instr_srai, instr_andi;
  logic [INSTR_W-1:0] instr_sub, instr_xor, instr_or, instr_and;
  logic [INSTR_W-1:0] instr_j, instr_beqz, instr_bnez;
  logic [19:0]        jal_imm;     // JAL imm[20|10:1|11|19:12]
  logic [6:0]         br_imm_hi;   // imm[12|10:5]
  logic [4:0]         br_imm_lo;   // imm[4:1|11]

  assign jal_imm   = {imm_j[11], imm_j[10:1], imm_j[11], {8{imm_j[11]}}};
  assign br_imm_hi = {imm_b[8], {3{imm_b[8]}}, imm_b[7:5]};
  assign br_imm_lo = {imm_b[4:1], imm_b[8]};

  assign instr_addi     = {imm_ci, rd_full, F3_ADD, rd_full, OPC_OP_IMM};  // C.NOP too
  assign instr_li       = {imm_ci, REG_ZERO, F3_ADD, rd_full, OPC_OP_IMM};
  assign instr_addi16sp = {imm_addi16sp, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
  assign instr_lui      = {imm_lui, rd_full, OPC_LUI};
  assign instr_jal      = {jal_imm, REG_RA, OPC_JAL};    // Link in ra
  assign instr_j        = {jal_imm, REG_ZERO, OPC_JAL};  // No link

  assign instr_srli = {F7_BASE, shamt, rs1_prime, F3_SRL, rs1_prime, OPC_OP_IMM};
  assign instr_srai = {F7_ALT, shamt, rs1_prime, F3_SRL, rs1_prime, OPC_OP_IMM};
  assign instr_andi = {imm_ci, rs1_prime, F3_AND, rs1_prime, OPC_OP_IMM};

  assign instr_sub = {F7_ALT, rs2_prime, rs1_prime, F3_ADD, rs1_prime, OPC_OP};
  assign instr_xor = {F7_BASE, rs2_prime, rs1_prime, F3_XOR, rs1_prime, OPC_OP};
  assign instr_or  = {F7_BASE, rs2_prime, rs1_prime, F3_OR, rs1_prime, OPC_OP};
  assign instr_and = {F7_BASE, rs2_prime, rs1_prime, F3_AND, rs1_prime, OPC_OP};

  // Compare against x0
  assign instr_beqz = {br_imm_hi, REG_ZERO, rs1_prime, F3_BEQ, br_imm_lo, OPC_BRANCH};
  assign instr_bnez = {br_imm_hi, REG_ZERO, rs1_prime, F3_BNE, br_imm_lo, OPC_BRANCH};

  // ========================================
  // One-hot selects
  // ========================================
  logic f3_011, f100, f100_alu;
  logic sel_addi, sel_jal, sel_li, sel_addi16sp, sel_lui;
  logic sel_srli, sel_srai, sel_andi, sel_sub, sel_xor, sel_or, sel_and;
  logic sel_j, sel_beqz, sel_bnez;

  assign f3_011   = (funct3 == 3'b011);
  assign f100     = (funct3 == 3'b100);
  assign f100_alu = f100 && (i_word.cb.funct2 == 2'b11) && !i_word.cb.imm_hi;

  assign sel_addi     = (funct3 == 3'b000);
  assign sel_jal      = (funct3 == 3'b001);
  assign sel_li       = (funct3 == 3'b010);
  assign sel_addi16sp = f3_011 && (rd_full == REG_SP);
  assign sel_lui      = f3_011 && (rd_full != REG_SP) && (rd_full != REG_ZERO);
  assign sel_j        = (funct3 == 3'b101);
  assign sel_beqz     = (funct3 == 3'b110);
  assign sel_bnez     = (funct3 == 3'b111);

  assign sel_srli = f100 && (i_word.cb.funct2 == 2'b00);
  assign sel_srai = f100 && (i_word.cb.funct2 == 2'b01);
  assign sel_andi = f100 && (i_word.cb.funct2 == 2'b10);
  assign sel_sub  = f100_alu && (i_word.cb.mid == 2'b00);
  assign sel_xor  = f100_alu && (i_word.cb.mid == 2'b01);
  assign sel_or   = f100_alu && (i_word.cb.mid == 2'b10);
  assign sel_and  = f100_alu && (i_word.cb.mid == 2'b11);

  assign o_result.instr = ({INSTR_W{sel_addi}}     & instr_addi) |
                          ({INSTR_W{sel_jal}}      & instr_jal) |
                          ({INSTR_W{sel_li}}       & instr_li) |
                          ({INSTR_W{sel_addi16sp}} & instr_addi16sp) |
                          ({INSTR_W{sel_lui}}      & instr_lui) |
                          ({INSTR_W{sel_srli}}     & instr_srli) |
                          ({INSTR_W{sel_srai}}     & instr_srai) |
                          ({INSTR_W{sel_andi}}     & instr_andi) |
                          ({INSTR_W{sel_sub}}      & instr_sub) |
                          ({INSTR_W{sel_xor}}      & instr_xor) |
                          ({INSTR_W{sel_or}}       & instr_or) |
                          ({INSTR_W{sel_and}}      & instr_and) |
                          ({INSTR_W{sel_j}}        & instr_j) |
                          ({INSTR_W{sel_beqz}}     & instr_beqz) |
                          ({INSTR_W{sel_bnez}}     & instr_bnez);

  // Illegal checks
  logic illegal_rd0, illegal_addi16sp, illegal_lui, illegal_shift, illegal_rv64;

  assign illegal_rd0      = f3_011 && (rd_full == REG_ZERO);
  assign illegal_addi16sp = sel_addi16sp && (imm_addi16sp == '0);
  assign illegal_lui      = sel_lui && ({i_word.ci.imm_hi, i_word.ci.imm_lo} == '0);
  assign illegal_shift    = (sel_srli || sel_srai) && i_word.cb.imm_hi;  // shamt[5]
  assign illegal_rv64     = f100 && (i_word.cb.funct2 == 2'b11) && i_word.cb.imm_hi;

  assign o_result.illegal = illegal_rd0 | illegal_addi16sp | illegal_lui |
                            illegal_shift | illegal_rv64;

endmodule : rvc_q1_expander

`default_nettype wire

// File: source/rvc_q0_expander.sv
`default_nettype none

module rvc_q0_expander import rvc_pkg::*; (
  input  rvc_word_u      i_word,
  output expand_result_t o_result
);

  // Prime registers, CL and CS share the layout
  logic [REG_W-1:0] rd_prime;  // Also rs2' for C.SW
  logic [REG_W-1:0] rs1_prime;

  assign rd_prime  = {PRIME_BASE, i_word.cl.rd_p};
  assign rs1_prime = {PRIME_BASE, i_word.cl.rs1_p};

  // ========================================
  // Immediates, scaled by 4
  // ========================================
  logic [11:0] imm_addi4spn;
  logic [11:0] imm_lw_sw;

  // nzuimm[5:4|9:6|2|3] in bits 12:5
  assign imm_addi4spn = {2'b00, i_word.ciw.imm[5:2], i_word.ciw.imm[7:6],
                         i_word.ciw.imm[0], i_word.ciw.imm[1], 2'b00};
  // uimm[5:3] at 12:10, uimm[2|6] at 6:5
  assign imm_lw_sw = {5'b0, i_word.cl.imm_lo[0], i_word.cl.imm_hi,
                      i_word.cl.imm_lo[1], 2'b00};

  // Expansions in parallel
  logic [INSTR_W-1:0] instr_addi4spn;
  logic [INSTR_W-1:0] instr_lw;
  logic [INSTR_W-1:0] instr_sw;

  assign instr_addi4spn = {imm_addi4spn, REG_SP, F3_ADD, rd_prime, OPC_OP_IMM};
  assign instr_lw       = {imm_lw_sw, rs1_prime, F3_WORD, rd_prime, OPC_LOAD};
  assign instr_sw       = {imm_lw_sw[11:5], rd_prime, rs1_prime, F3_WORD,
                           imm_lw_sw[4:0], OPC_STORE};

  // ========================================
  // One-hot selects
  // ========================================
  logic sel_addi4spn;
  logic sel_lw;
  logic sel_sw;

  assign sel_addi4spn = (i_word.ciw.funct3 == 3'b000);
  assign sel_lw       = (i_word.cl.funct3 == 3'b010);
  assign sel_sw       = (i_word.cl.funct3 == 3'b110);  // CS format

  // Reserved codes and the dropped float forms select nothing
  logic illegal_reserved;
  logic illegal_addi4spn;

  assign illegal_reserved = !(sel_addi4spn || sel_lw || sel_sw);
  assign illegal_addi4spn = sel_addi4spn && (imm_addi4spn == '0);  // Zero is reserved

  assign o_result.instr = ({INSTR_W{sel_addi4spn}} & instr_addi4spn) |
                          ({INSTR_W{sel_lw}}       & instr_lw) |
                          ({INSTR_W{sel_sw}}       & instr_sw);

  assign o_result.illegal = illegal_reserved | illegal_addi4spn;

endmodule : rvc_q0_expander

`default_nettype wire

// File: source/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int CINSTR_W = 16;  // Compressed word
  localparam int INSTR_W  = 32;  // Expanded RV32I word
  localparam int REG_W    = 5;   // Register specifier

  // Quadrant codes from bits 1:0
  localparam logic [1:0] QUAD_0 = 2'b00;
  localparam logic [1:0] QUAD_1 = 2'b01;
  localparam logic [1:0] QUAD_2 = 2'b10;
  localparam logic [1:0] QUAD_3 = 2'b11;  // Not compressed

  // ========================================
  // RV32I encoding fields
  // ========================================
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // ALU funct3, also 000 for JALR
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SRL = 3'b101;  // SRLI and SRAI
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [2:0] F3_WORD = 3'b010;  // LW / SW width
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRAI

  // Architectural registers
  localparam logic [REG_W-1:0] REG_ZERO = 5'd0;
  localparam logic [REG_W-1:0] REG_RA   = 5'd1;
  localparam logic [REG_W-1:0] REG_SP   = 5'd2;

  // Prefix so a 3-bit field reaches x8..x15
  localparam logic [1:0] PRIME_BASE = 2'b01;

  localparam logic [INSTR_W-1:0] EBREAK_WORD = 32'h0010_0073;

  // ========================================
  // Compressed formats
  // ========================================

  // CR, funct4 replaces funct3
  typedef struct packed {
    logic [3:0]       funct4;  // 15:12
    logic [REG_W-1:0] rd_rs1;  // 11:7
    logic [REG_W-1:0] rs2;     // 6:2
    logic [1:0]       op;
  } cr_fmt_t;

  typedef struct packed {
    logic [2:0]       funct3;
    logic             imm_hi;  // Bit 12
    logic [REG_W-1:0] rd_rs1;
    logic [4:0]       imm_lo;  // 6:2
    logic [1:0]       op;
  } ci_fmt_t;

  // Stack-relative store
  typedef struct packed {
    logic [2:0]       funct3;
    logic [5:0]       imm;  // 12:7
    logic [REG_W-1:0] rs2;
    logic [1:0]       op;
  } css_fmt_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;   // 12:5
    logic [2:0] rd_p;  // 4:2
    logic [1:0] op;
  } ciw_fmt_t;

  // CL, also read as CS with rd_p as rs2'
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;  // 12:10
    logic [2:0] rs1_p;   // 9:7
    logic [1:0] imm_lo;  // 6:5
    logic [2:0] rd_p;    // 4:2
    logic [1:0] op;
  } cl_fmt_t;

  // CB plus the funct3 100 arithmetic group
  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;  // Bit 12
    logic [1:0] funct2;  // 11:10
    logic [2:0] rs1_p;
    logic [1:0] mid;     // 6:5, ALU op too
    logic [2:0] imm_lo;  // 4:2, rs2' too
    logic [1:0] op;
  } cb_fmt_t;

  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;  // 12:2
    logic [1:0]  op;
  } cj_fmt_t;

  // One 16-bit word, seven views
  typedef union packed {
    cr_fmt_t  cr;
    ci_fmt_t  ci;
    css_fmt_t css;
    ciw_fmt_t ciw;
    cl_fmt_t  cl;
    cb_fmt_t  cb;
    cj_fmt_t  cj;
  } rvc_word_u;

  // Per-quadrant expansion
  typedef struct packed {
    logic [INSTR_W-1:0] instr;
    logic               illegal;
  } expand_result_t;

endpackage : rvc_pkg

`default_nettype wire
